//--- compile.f
source/cgra_pkg.sv
source/cgra_conf_reader.sv
source/cgra_thread_seq.sv
source/cgra_alu.sv
source/cgra_pe_in.sv
source/cgra_pe_out.sv
source/cgra_top.sv
sim/tb_clock.sv
sim/cgra_chk.sv
sim/cgra_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cgra slice testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module cgra_tb -f compile.f \
  && ./obj_dir/Vcgra_tb | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

//--- sim/cgra_chk.sv
`timescale 1ns/1ps

module cgra_chk (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 en,
  input cgra_pkg::conf_word_t conf_bus,
  input logic                 fifo0_re,
  input logic                 fifo1_re,
  input logic                 out_we,
  input cgra_pkg::data_t      out_data,
  input cgra_pkg::data_t      lane0_outb,
  input cgra_pkg::data_t      lane1_outb
);
  import cgra_pkg::*;

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_we && !fifo0_re && !fifo1_re)
    else $error("strobe active during reset");

  // a low en at one edge means nothing moved at that edge.
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !en |=> $stable(out_data) && $stable(out_we) && $stable(lane0_outb) && $stable(lane1_outb))
    else $error("output changed while en was low");

  a_ignore_load: assert property (@(posedge clk) disable iff (!rst_n)
    conf_bus.valid && conf_bus.pe_id == 2'd0 && conf_bus.kind == IGNORE |-> !$rose(fifo0_re))
    else $error("fifo0 read started during an ignore-limit load");

endmodule

bind cgra_top cgra_chk u_chk (
  .clk, .rst_n, .en, .conf_bus, .fifo0_re, .fifo1_re,
  .out_we, .out_data, .lane0_outb, .lane1_outb
);

//--- sim/cgra_tb.sv
`timescale 1ns/1ps

module cgra_tb;
  import cgra_pkg::*;

  localparam int ROWS        = 7;
  localparam int EXTRA_TESTS = 2;
  localparam int SETTLE      = 2 * PIPE_DEPTH + 2;
  localparam int FIFO_SLOTS  = 10;
  localparam int IGNORE_K    = 2;

  typedef struct packed {
    alu_op_e op0, op1, opm;
    logic    use_rf;
    data_t   konst, in0_a, in0_b, in1_a, in1_b;
    data_t   exp_l0, exp_l1, exp_out;
    logic    exp_br;
  } row_t;

  logic       clk, rst_n, en;
  conf_word_t conf_bus;
  data_t      in0_a, in0_b, in1_a, in1_b, fifo0_data, fifo1_data;
  logic       fifo0_re, fifo1_re, out_we, branch_out;
  data_t      lane0_outb, lane1_outb, out_data;
  data_t      fifo0_mem [32];
  data_t      fifo1_mem [32];
  int         rd0 = 0;
  int         rd1 = 0;
  int         we_count = 0;
  int         errors = 0;
  int         seed = 32'h34eb_422f;
  row_t       table_q [ROWS];

  tb_clock u_clock (.clk, .rst_n);

  cgra_top dut (
    .clk, .rst_n, .en, .conf_bus, .in0_a, .in0_b, .in1_a, .in1_b,
    .fifo0_data, .fifo1_data, .fifo0_re, .fifo1_re, .lane0_outb, .lane1_outb,
    .out_data, .out_we, .branch_out
  );

  assign fifo0_data = fifo0_mem[rd0 % 32];
  assign fifo1_data = fifo1_mem[rd1 % 32];

  // fifo models pop on the strobe seen at the edge.
  always @(posedge clk) begin
    logic pop0, pop1;
    pop0 = fifo0_re;
    pop1 = fifo1_re;
    if (en && out_we) we_count++;
    #2;
    if (pop0) rd0++;
    if (pop1) rd1++;
  end

  initial begin
    repeat ((ROWS + EXTRA_TESTS) * 200) @(posedge clk);
    $display("watchdog expired before the tests finished");
    stop_on_error();
  end

  task automatic stop_on_error();
    errors++;
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      $display("ERROR: time %0t %s = %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR: time %0t %s = %b, expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      $display("ERROR: time %0t %s = %0d, expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  function automatic data_t alu_model(alu_op_e op, data_t a, data_t b, logic br);
    case (op)
      ADD:            return a + b;
      SUB:            return a - b;
      MUL:            return a * b;
      AND:            return a & b;
      OR:             return a | b;
      XOR:            return a ^ b;
      SHL:            return a << b[3:0];
      SHR:            return a >> b[3:0];
      PASS_A, CMP_EQ: return a;
      PASS_B:         return b;
      CMOV:           return br ? a : b;
      default:        return '0;
    endcase
  endfunction

  function automatic row_t with_expected(row_t r);
    logic br0, br1;
    br0      = (r.op0 == CMP_EQ) ? (r.in0_a == r.in0_b) : 1'b0; // chain starts at zero.
    r.exp_l0 = alu_model(r.op0, r.in0_a, r.in0_b, 1'b0);
    br1      = (r.op1 == CMP_EQ) ? (r.in1_a == (r.use_rf ? r.konst : r.in1_b)) : br0;
    r.exp_l1 = alu_model(r.op1, r.in1_a, r.use_rf ? r.konst : r.in1_b, br0);
    r.exp_out = alu_model(r.opm, r.exp_l0, r.exp_l1, br1);
    r.exp_br = (r.opm == CMP_EQ) ? (r.exp_l0 == r.exp_l1) : br1;
    return r;
  endfunction

  function automatic data_t mk_instr(alu_op_e op, logic src_a, logic src_b, logic fifo,
                                     logic oa, logic ob, rf_addr_t raddr);
    instr_t i;
    i          = '0;
    i.op       = op;
    i.src_a    = src_a;
    i.src_b    = src_b;
    i.fifo     = fifo;
    i.out_a_en = oa;
    i.out_b_en = ob;
    i.rf_raddr = raddr;
    return data_t'(i);
  endfunction

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic write_conf(pe_id_t pe, conf_kind_e kind, thread_t thr, pc_t addr, data_t data);
    conf_bus        = '0;
    conf_bus.valid  = 1'b1;
    conf_bus.pe_id  = pe;
    conf_bus.kind   = kind;
    conf_bus.thread = thr;
    conf_bus.addr   = addr;
    conf_bus.data   = data;
    tick();
    conf_bus = '0;
  endtask

  task automatic run_enabled(int n);
    en = 1'b1;
    repeat (n) tick();
    en = 1'b0;
  endtask

  task automatic load_row(row_t r);
    for (int t = 0; t < NUM_THREADS; t++) begin
      write_conf(2'd0, INSTR, thread_t'(t), 8'd0,
                 mk_instr(r.op0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 3'd0));
      write_conf(2'd1, INSTR, thread_t'(t), 8'd0,
                 mk_instr(r.op1, 1'b0, r.use_rf, 1'b0, 1'b1, 1'b1, 3'd3));
      write_conf(2'd1, CONST, thread_t'(t), 8'd3, r.konst);
      write_conf(2'd2, INSTR, thread_t'(t), 8'd0,
                 mk_instr(r.opm, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 3'd0));
    end
    tick(); // last write lands.
  endtask

  task automatic fifo_ignore_test();
    int    cnt [NUM_THREADS];
    int    mptr;
    int    pulses;
    int    thr;
    logic  act;
    data_t exp_q [$];
    for (int t = 0; t < NUM_THREADS; t++) begin
      write_conf(2'd0, INSTR, thread_t'(t), 8'd0,
                 mk_instr(PASS_A, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 3'd0));
      write_conf(2'd1, INSTR, thread_t'(t), 8'd0,
                 mk_instr(PASS_A, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 3'd0));
      write_conf(2'd2, INSTR, thread_t'(t), 8'd0, 16'h0000);
    end
    write_conf(2'd0, IGNORE, 1'b0, 8'd0, data_t'(IGNORE_K)); // thread 0 only.
    tick();
    cnt    = '{default: 0};
    mptr   = 0;
    pulses = 0;
    en     = 1'b1;
    for (int c = 1; c <= FIFO_SLOTS + 1; c++) begin
      tick();
      if (c == FIFO_SLOTS + 1) en = 1'b0;
      @(negedge clk);
      if (c <= FIFO_SLOTS) begin
        thr = (c - 1) % NUM_THREADS;
        act = cnt[thr] >= ((thr == 0) ? IGNORE_K : 0);
        exp_q.push_back(fifo0_mem[mptr]);
        if (act) mptr++;
        else cnt[thr]++;
        if (fifo0_re) pulses++;
        check_flag("fifo0_re", fifo0_re, act);
        check_flag("fifo1_re", fifo1_re, 1'b1); // lane 1 has no ignore limit.
      end
      if (c > 3) check_data("lane0_outb", lane0_outb, exp_q.pop_front());
    end
    check_count("fifo0_re pulses", pulses, FIFO_SLOTS - IGNORE_K);
    tick();
  endtask

  task automatic loop_test(data_t l0, data_t l1);
    data_t sum, diff, want;
    logic  got_first, prev_we;
    sum  = l0 + l1;
    diff = l0 - l1;
    for (int t = 0; t < NUM_THREADS; t++) begin
      write_conf(2'd2, PC_MAX, thread_t'(t), 8'd0, 16'd1);
      write_conf(2'd2, INSTR, thread_t'(t), 8'd1, 16'h0000);
    end
    write_conf(2'd2, INSTR, 1'b0, 8'd0, 16'h0000);
    write_conf(2'd2, INSTR, 1'b1, 8'd0, mk_instr(ADD, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 3'd0));
    write_conf(2'd2, INSTR, 1'b1, 8'd1, mk_instr(SUB, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 3'd0));
    tick();
    run_enabled(SETTLE);
    en        = 1'b1;
    got_first = 1'b0;
    prev_we   = 1'b0;
    want      = '0;
    for (int c = 1; c <= 8; c++) begin
      tick();
      @(negedge clk);
      if (c > 1) check_flag("out_we", out_we, !prev_we);
      prev_we = out_we;
      if (out_we) begin
        if (got_first) begin
          check_data("out_data", out_data, want);
        end else if (out_data !== sum && out_data !== diff) begin
          $display("loop output %h matches neither loop instruction", out_data);
          stop_on_error();
        end
        want      = (out_data == sum) ? diff : sum;
        got_first = 1'b1;
      end
    end
    tick();
    en = 1'b0;
  endtask

  initial begin
    int    seen;
    data_t held;
    en       = 1'b0;
    conf_bus = '0;
    in0_a    = '0;
    in0_b    = '0;
    in1_a    = '0;
    in1_b    = '0;
    for (int i = 0; i < 32; i++) begin
      fifo0_mem[i] = data_t'(32'h3c00 + i * 32'h0113);
      fifo1_mem[i] = data_t'(32'h8100 ^ (i * 32'h0247));
    end
    table_q[0] = '{op0: ADD, op1: SUB, opm: MUL, default: '0};
    table_q[1] = '{op0: MUL, op1: XOR, opm: ADD, default: '0};
    table_q[2] = '{op0: AND, op1: OR, opm: XOR, default: '0};
    table_q[3] = '{op0: SHL, op1: SHR, opm: SUB, default: '0};
    table_q[4] = '{op0: PASS_A, op1: ADD, opm: PASS_B, use_rf: 1'b1, default: '0};
    table_q[5] = '{op0: CMP_EQ, op1: PASS_A, opm: CMOV, default: '0};
    table_q[6] = '{op0: CMP_EQ, op1: PASS_A, opm: CMOV, default: '0};
    for (int r = 0; r < ROWS; r++) begin
      table_q[r].konst = data_t'($random(seed));
      table_q[r].in0_a = data_t'($random(seed));
      table_q[r].in0_b = data_t'($random(seed));
      table_q[r].in1_a = data_t'($random(seed));
      table_q[r].in1_b = data_t'($random(seed));
    end
    table_q[5].in0_b = table_q[5].in0_a; // equal operands take lane 0.
    for (int r = 0; r < ROWS; r++) table_q[r] = with_expected(table_q[r]);

    wait (rst_n === 1'b1);
    tick();
    fifo_ignore_test();

    for (int r = 0; r < ROWS; r++) begin
      load_row(table_q[r]);
      in0_a = table_q[r].in0_a;
      in0_b = table_q[r].in0_b;
      in1_a = table_q[r].in1_a;
      in1_b = table_q[r].in1_b;
      run_enabled(SETTLE);
      check_data("out_data", out_data, table_q[r].exp_out);
      check_data("lane0_outb", lane0_outb, table_q[r].exp_l0);
      check_data("lane1_outb", lane1_outb, table_q[r].exp_l1);
      check_flag("branch_out", branch_out, table_q[r].exp_br);
      // hold en low, then resume.
      seen = we_count;
      held = out_data;
      repeat (5) tick();
      check_data("out_data", out_data, held);
      check_data("lane0_outb", lane0_outb, table_q[r].exp_l0);
      check_data("lane1_outb", lane1_outb, table_q[r].exp_l1);
      check_flag("out_we", out_we, 1'b1); // every merge slot writes, the strobe stays frozen.
      run_enabled(SETTLE);
      check_count("out_we pulses", we_count, seen + SETTLE);
      check_data("out_data", out_data, table_q[r].exp_out);
    end

    loop_test(table_q[ROWS-1].exp_l0, table_q[ROWS-1].exp_l1);

    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter realtime PERIOD = 40ns
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #2 rst_n = 1'b1; // released just after the second edge.
  end

endmodule

//--- source/cgra_alu.sv
`timescale 1ns/1ps

module cgra_alu (
  input  cgra_pkg::alu_op_e op,
  input  cgra_pkg::data_t   ina,
  input  cgra_pkg::data_t   inb,
  input  logic              branch_in,
  output cgra_pkg::data_t   result,
  output logic              branch_out
);
  import cgra_pkg::*;

  logic [31:0] product;

  assign product = ina * inb;

  always_comb begin
    branch_out = branch_in; // flag passes through unless compared.
    case (op)
      NOP:     result = '0;
      ADD:     result = ina + inb;
      SUB:     result = ina - inb;
      MUL:     result = product[15:0];
      AND:     result = ina & inb;
      OR:      result = ina | inb;
      XOR:     result = ina ^ inb;
      SHL:     result = ina << inb[3:0];
      SHR:     result = ina >> inb[3:0];
      PASS_A:  result = ina;
      PASS_B:  result = inb;
      CMP_EQ: begin
        result     = ina;
        branch_out = (ina == inb);
      end
      CMOV:    result = branch_in ? ina : inb;
      default: result = '0;
    endcase
  end

endmodule

//--- source/cgra_conf_reader.sv
`timescale 1ns/1ps

module cgra_conf_reader #(
  parameter cgra_pkg::pe_id_t PE_ID = 2'd0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cgra_pkg::conf_word_t conf_bus,
  output logic                 imem_we,
  output logic                 rf_const_we,
  output logic                 pc_max_we,
  output logic                 pc_loop_we,
  output logic                 ignore_we,
  output cgra_pkg::thread_t    thread,
  output cgra_pkg::pc_t        addr,
  output cgra_pkg::data_t      data
);
  import cgra_pkg::*;

  logic hit;

  assign hit = conf_bus.valid && (conf_bus.pe_id == PE_ID);

  // one-hot strobes, one edge behind the bus word.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      imem_we     <= 1'b0;
      rf_const_we <= 1'b0;
      pc_max_we   <= 1'b0;
      pc_loop_we  <= 1'b0;
      ignore_we   <= 1'b0;
    end else begin
      imem_we     <= hit && (conf_bus.kind == INSTR);
      rf_const_we <= hit && (conf_bus.kind == CONST);
      pc_max_we   <= hit && (conf_bus.kind == PC_MAX);
      pc_loop_we  <= hit && (conf_bus.kind == PC_LOOP);
      ignore_we   <= hit && (conf_bus.kind == IGNORE);
    end
  end

  always_ff @(posedge clk) begin
    thread <= conf_bus.thread;
    addr   <= conf_bus.addr;
    data   <= conf_bus.data;
  end

endmodule

//--- source/cgra_pe_in.sv
`timescale 1ns/1ps

module cgra_pe_in #(
  parameter cgra_pkg::pe_id_t PE_ID = 2'd0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 en,
  input  cgra_pkg::conf_word_t conf_bus,
  input  cgra_pkg::data_t      ina,
  input  cgra_pkg::data_t      inb,
  input  cgra_pkg::data_t      fifo_data,
  input  logic                 branch_in,
  output cgra_pkg::data_t      outa,
  output cgra_pkg::data_t      outb,
  output logic                 branch_out,
  output logic                 fifo_re
);
  import cgra_pkg::*;

  logic       imem_we, rf_const_we, pc_max_we, pc_loop_we, ignore_we;
  thread_t    c_thread;
  pc_t        c_addr;
  data_t      c_data;
  thread_t    thread;
  pc_t        fetch_pc;
  instr_t     imem [NUM_THREADS << $bits(pc_t)];
  data_t      rf   [NUM_THREADS * RF_DEPTH];
  instr_t     instr_s1;
  thread_t    thr_q [1:PIPE_DEPTH-1]; // thread tag per stage.
  stage_ctl_t ctl_s2, ctl_s3;
  data_t      opa_s2, opb_s2, alu_res, alu_s3;
  logic       br_s2, br_alu, br_s3;
  cnt_t       ignore_lim [NUM_THREADS];
  cnt_t       ignore_cnt [NUM_THREADS];
  logic       ignore_done;

  cgra_conf_reader #(.PE_ID(PE_ID)) u_conf (
    .clk, .rst_n, .conf_bus,
    .imem_we, .rf_const_we, .pc_max_we, .pc_loop_we, .ignore_we,
    .thread(c_thread), .addr(c_addr), .data(c_data)
  );

  cgra_thread_seq u_seq (
    .clk, .rst_n, .en, .pc_max_we, .pc_loop_we,
    .conf_thread(c_thread), .conf_value(c_data[$bits(pc_t)-1:0]),
    .thread, .fetch_pc
  );

  always_ff @(posedge clk) begin
    if (imem_we) imem[{c_thread, c_addr}] <= instr_t'(c_data);
  end

  // fetch stage.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_s1 <= '0;
      for (int i = 1; i < PIPE_DEPTH; i++) thr_q[i] <= '0;
    end else if (en) begin
      instr_s1 <= imem[{thread, fetch_pc}];
      thr_q[1] <= thread;
      for (int i = 2; i < PIPE_DEPTH; i++) thr_q[i] <= thr_q[i-1];
    end
  end

  // first reads of each thread are dropped until its counter hits the limit.
  assign ignore_done = ignore_cnt[thr_q[1]] >= ignore_lim[thr_q[1]];
  assign fifo_re     = instr_s1.fifo & en & ignore_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int t = 0; t < NUM_THREADS; t++) begin
        ignore_lim[t] <= '0;
        ignore_cnt[t] <= '0;
      end
    end else begin
      if (ignore_we) ignore_lim[c_thread] <= c_data[$bits(cnt_t)-1:0];
      if (en && instr_s1.fifo && !ignore_done) begin
        ignore_cnt[thr_q[1]] <= ignore_cnt[thr_q[1]] + 1'b1;
      end
    end
  end

  // decode and operand stage, then alu result and output registers.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctl_s2     <= '0;
      ctl_s3     <= '0;
      br_s2      <= 1'b0;
      br_s3      <= 1'b0;
      outa       <= '0;
      outb       <= '0;
      branch_out <= 1'b0;
    end else if (en) begin
      ctl_s2 <= '{op: instr_s1.op, rf_we: instr_s1.rf_we, fifo: instr_s1.fifo,
                  out_a_en: instr_s1.out_a_en, out_b_en: instr_s1.out_b_en,
                  rf_waddr: instr_s1.rf_waddr};
      br_s2      <= branch_in;
      ctl_s3     <= ctl_s2;
      br_s3      <= br_alu;
      branch_out <= br_s3;
      if (ctl_s3.out_a_en) outa <= alu_s3;
      if (ctl_s3.out_b_en) outb <= alu_s3;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      opa_s2 <= instr_s1.src_a ? fifo_data : ina;
      opb_s2 <= instr_s1.src_b ? rf[{thr_q[1], instr_s1.rf_raddr}] : inb;
      alu_s3 <= alu_res;
    end
  end

  cgra_alu u_alu (
    .op(ctl_s2.op), .ina(opa_s2), .inb(opb_s2), .branch_in(br_s2),
    .result(alu_res), .branch_out(br_alu)
  );

  // constant loads win over a writeback in the same cycle.
  always_ff @(posedge clk) begin
    if (rf_const_we) begin
      rf[{c_thread, c_addr[$bits(rf_addr_t)-1:0]}] <= c_data;
    end else if (en && ctl_s3.rf_we) begin
      rf[{thr_q[PIPE_DEPTH-1], ctl_s3.rf_waddr}] <= alu_s3;
    end
  end

endmodule

//--- source/cgra_pe_out.sv
`timescale 1ns/1ps

module cgra_pe_out #(
  parameter cgra_pkg::pe_id_t PE_ID = 2'd2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 en,
  input  cgra_pkg::conf_word_t conf_bus,
  input  cgra_pkg::data_t      ina,
  input  cgra_pkg::data_t      inb,
  input  logic                 branch_in,
  output cgra_pkg::data_t      out_data,
  output logic                 out_we,
  output logic                 branch_out
);
  import cgra_pkg::*;

  logic       imem_we, rf_const_we, pc_max_we, pc_loop_we;
  thread_t    c_thread;
  pc_t        c_addr;
  data_t      c_data;
  thread_t    thread;
  pc_t        fetch_pc;
  instr_t     imem [NUM_THREADS << $bits(pc_t)];
  data_t      rf   [NUM_THREADS * RF_DEPTH];
  instr_t     instr_s1;
  thread_t    thr_q [1:PIPE_DEPTH-1];
  stage_ctl_t ctl_s2, ctl_s3;
  data_t      opa_s2, opb_s2, alu_res, alu_s3;
  logic       br_s2, br_alu, br_s3;

  cgra_conf_reader #(.PE_ID(PE_ID)) u_conf (
    .clk, .rst_n, .conf_bus,
    .imem_we, .rf_const_we, .pc_max_we, .pc_loop_we, .ignore_we(),
    .thread(c_thread), .addr(c_addr), .data(c_data)
  );

  cgra_thread_seq u_seq (
    .clk, .rst_n, .en, .pc_max_we, .pc_loop_we,
    .conf_thread(c_thread), .conf_value(c_data[$bits(pc_t)-1:0]),
    .thread, .fetch_pc
  );

  always_ff @(posedge clk) begin
    if (imem_we) imem[{c_thread, c_addr}] <= instr_t'(c_data);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_s1   <= '0;
      ctl_s2     <= '0;
      ctl_s3     <= '0;
      br_s2      <= 1'b0;
      br_s3      <= 1'b0;
      out_data   <= '0;
      out_we     <= 1'b0;
      branch_out <= 1'b0;
      for (int i = 1; i < PIPE_DEPTH; i++) thr_q[i] <= '0;
    end else if (en) begin
      instr_s1 <= imem[{thread, fetch_pc}];
      thr_q[1] <= thread;
      for (int i = 2; i < PIPE_DEPTH; i++) thr_q[i] <= thr_q[i-1];
      ctl_s2 <= '{op: instr_s1.op, rf_we: instr_s1.rf_we, fifo: instr_s1.fifo,
                  out_a_en: instr_s1.out_a_en, out_b_en: instr_s1.out_b_en,
                  rf_waddr: instr_s1.rf_waddr};
      br_s2      <= branch_in;
      ctl_s3     <= ctl_s2;
      br_s3      <= br_alu;
      branch_out <= br_s3;
      out_we     <= ctl_s3.fifo; // frozen with the pipeline while en is low.
      // out_a_en alone updates out_data without a write.
      if (ctl_s3.fifo || ctl_s3.out_a_en) out_data <= alu_s3;
    end
  end

  // operand a is lane 0 or lane 1, operand b is lane 1 or a register.
  always_ff @(posedge clk) begin
    if (en) begin
      opa_s2 <= instr_s1.src_a ? ina : inb;
      opb_s2 <= instr_s1.src_b ? rf[{thr_q[1], instr_s1.rf_raddr}] : inb;
      alu_s3 <= alu_res;
    end
  end

  cgra_alu u_alu (
    .op(ctl_s2.op), .ina(opa_s2), .inb(opb_s2), .branch_in(br_s2),
    .result(alu_res), .branch_out(br_alu)
  );

  always_ff @(posedge clk) begin
    if (rf_const_we) begin
      rf[{c_thread, c_addr[$bits(rf_addr_t)-1:0]}] <= c_data;
    end else if (en && ctl_s3.rf_we) begin
      rf[{thr_q[PIPE_DEPTH-1], ctl_s3.rf_waddr}] <= alu_s3;
    end
  end

endmodule

//--- source/cgra_pkg.sv
package cgra_pkg;

  localparam int NUM_THREADS = 2;
  localparam int RF_DEPTH    = 8;
  localparam int PIPE_DEPTH  = 4; // enabled edges from issue to output register.

  typedef logic [15:0]                      data_t;
  typedef logic [7:0]                       pc_t;
  typedef logic [$clog2(NUM_THREADS)-1:0]   thread_t;
  typedef logic [$clog2(RF_DEPTH)-1:0]      rf_addr_t;
  typedef logic [1:0]                       pe_id_t;
  typedef logic [7:0]                       cnt_t; // ignore limits and counters.

  typedef enum logic [2:0] {
    INSTR,
    CONST,
    PC_MAX,
    PC_LOOP,
    IGNORE
  } conf_kind_e;

  // codes 13 to 15 are undefined and give zero.
  typedef enum logic [3:0] {
    NOP    = 4'd0,
    ADD    = 4'd1,
    SUB    = 4'd2,
    MUL    = 4'd3,
    AND    = 4'd4,
    OR     = 4'd5,
    XOR    = 4'd6,
    SHL    = 4'd7,
    SHR    = 4'd8,
    PASS_A = 4'd9,
    PASS_B = 4'd10,
    CMP_EQ = 4'd11,
    CMOV   = 4'd12
  } alu_op_e;

  typedef struct packed {
    logic       valid;
    pe_id_t     pe_id;
    conf_kind_e kind;
    thread_t    thread;
    pc_t        addr;
    data_t      data;
    logic [32:0] pad;
  } conf_word_t;

  typedef struct packed {
    alu_op_e  op;
    logic     src_a;    // 1 selects fifo in a lane, lane 0 in the merge element.
    logic     src_b;    // 1 selects the register file.
    logic     rf_we;
    logic     fifo;     // read strobe in a lane, write strobe in the merge element.
    logic     out_a_en;
    logic     out_b_en;
    rf_addr_t rf_raddr;
    rf_addr_t rf_waddr;
  } instr_t;

  // control fields carried down the pipeline after decode.
  typedef struct packed {
    alu_op_e  op;
    logic     rf_we;
    logic     fifo;
    logic     out_a_en;
    logic     out_b_en;
    rf_addr_t rf_waddr;
  } stage_ctl_t;

endpackage

//--- source/cgra_thread_seq.sv
`timescale 1ns/1ps

module cgra_thread_seq (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              en,
  input  logic              pc_max_we,
  input  logic              pc_loop_we,
  input  cgra_pkg::thread_t conf_thread,
  input  cgra_pkg::pc_t     conf_value,
  output cgra_pkg::thread_t thread,
  output cgra_pkg::pc_t     fetch_pc
);
  import cgra_pkg::*;

  pc_t pc      [NUM_THREADS];
  pc_t pc_max  [NUM_THREADS];
  pc_t pc_loop [NUM_THREADS];

  assign fetch_pc = pc[thread];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      thread <= '0;
      for (int t = 0; t < NUM_THREADS; t++) begin
        pc[t]      <= '0;
        pc_max[t]  <= '0;
        pc_loop[t] <= '0;
      end
    end else begin
      if (pc_max_we) pc_max[conf_thread] <= conf_value;
      if (pc_loop_we) pc_loop[conf_thread] <= conf_value;
      if (en) begin
        // only the issuing thread moves; wraps to its loop start.
        if (pc[thread] == pc_max[thread]) begin
          pc[thread] <= pc_loop[thread];
        end else begin
          pc[thread] <= pc[thread] + 1'b1;
        end
        thread <= thread + 1'b1; // round robin.
      end
    end
  end

endmodule

//--- source/cgra_top.sv
`timescale 1ns/1ps

module cgra_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 en,
  input  cgra_pkg::conf_word_t conf_bus,
  input  cgra_pkg::data_t      in0_a,
  input  cgra_pkg::data_t      in0_b,
  input  cgra_pkg::data_t      in1_a,
  input  cgra_pkg::data_t      in1_b,
  input  cgra_pkg::data_t      fifo0_data,
  input  cgra_pkg::data_t      fifo1_data,
  output logic                 fifo0_re,
  output logic                 fifo1_re,
  output cgra_pkg::data_t      lane0_outb,
  output cgra_pkg::data_t      lane1_outb,
  output cgra_pkg::data_t      out_data,
  output logic                 out_we,
  output logic                 branch_out
);
  import cgra_pkg::*;

  data_t lane0_outa, lane1_outa;
  logic  lane0_branch, lane1_branch;

  cgra_pe_in #(.PE_ID(2'd0)) u_lane0 (
    .clk, .rst_n, .en, .conf_bus,
    .ina(in0_a), .inb(in0_b), .fifo_data(fifo0_data),
    .branch_in(1'b0), // head of the branch chain.
    .outa(lane0_outa), .outb(lane0_outb),
    .branch_out(lane0_branch), .fifo_re(fifo0_re)
  );

  cgra_pe_in #(.PE_ID(2'd1)) u_lane1 (
    .clk, .rst_n, .en, .conf_bus,
    .ina(in1_a), .inb(in1_b), .fifo_data(fifo1_data),
    .branch_in(lane0_branch),
    .outa(lane1_outa), .outb(lane1_outb),
    .branch_out(lane1_branch), .fifo_re(fifo1_re)
  );

  cgra_pe_out #(.PE_ID(2'd2)) u_merge (
    .clk, .rst_n, .en, .conf_bus,
    .ina(lane0_outa), .inb(lane1_outa),
    .branch_in(lane1_branch),
    .out_data, .out_we, .branch_out
  );

endmodule
